// File: testbench/exec_core_testdata.txt
# instr kind rd value addr, all hex
# kind 0 NONE, 1 WRITE, 2 STORE, 3 ILLEGAL
06400093 1 01 00000064 00000000
FF900113 1 02 FFFFFFF9 00000000
0F00E193 1 03 000000F4 00000000
0FF17213 1 04 000000F9 00000000
FFF0C293 1 05 FFFFFF9B 00000000
80000337 1 06 80000000 00000000
123453B7 1 07 12345000 00000000
00208433 1 08 0000005D 00000000
402084B3 1 09 0000006B 00000000
0041F533 1 0A 000000F0 00000000
0041E5B3 1 0B 000000FD 00000000
0041C633 1 0C 0000000D 00000000
001126B3 1 0D 00000001 00000000
00113733 1 0E 00000000 00000000
0020A7B3 1 0F 00000000 00000000
0020B833 1 10 00000001 00000000
02400893 1 11 00000024 00000000
01109933 1 12 00000640 00000000
011359B3 1 13 08000000 00000000
41135A33 1 14 F8000000 00000000
41115AB3 1 15 FFFFFFFF 00000000
01115B33 1 16 0FFFFFFF 00000000
00112B93 1 17 00000001 00000000
FFF0BC13 1 18 00000001 00000000
FFF0AC93 1 19 00000000 00000000
00809D13 1 1A 00006400 00000000
01F35D93 1 1B 00000001 00000000
41F35E13 1 1C FFFFFFFF 00000000
00513E93 1 1D 00000000 00000000
0070A823 2 00 12345000 00000074
FE20AE23 2 00 FFFFFFF9 00000060
0100AF03 1 1E 12345000 00000074
06002F83 1 1F FFFFFFF9 00000060
20002B03 1 16 00000000 00000200
00508013 0 00 00000000 00000000
0100A003 0 00 00000000 00000074
001004B3 1 09 00000064 00000000
00208463 3 00 00000000 00000000
00040513 1 0A 0000005D 00000000
010002EF 3 00 00000000 00000000
00028593 1 0B FFFFFF9B 00000000
FFFFFFFF 3 00 00000000 00000000
000F8613 1 0C FFFFFFF9 00000000
022086B3 3 00 00000000 00000000
00068713 1 0E 00000001 00000000

// File: all.f
+incdir+include
rtl/rv_core_pkg.sv
rtl/control.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/data_mem.sv
rtl/exec_core.sv
testbench/exec_core_asserts.sv
testbench/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench; exit status is nonzero on failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module exec_core_tb -f all.f -o exec_core_sim &&
./obj_dir/exec_core_sim ||
{ echo "simulation failed"; exit 1; }

// File: testbench/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;
	import rv_core_pkg::*;

	logic        clk;
	logic        rst;
	logic        instr_valid;
	logic [31:0] instr;
	retire_t     retire;

	// Vectors from the data file, one entry per instruction
	logic [31:0] vec_instr [$];
	logic [31:0] vec_kind [$];
	logic [31:0] vec_rd [$];
	logic [31:0] vec_value [$];
	logic [31:0] vec_addr [$];

	int seed = 3973;
	int cycle_count = 0;
	int timeout_limit = 1000;

	exec_core uut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.retire      (retire)
	);

	bind exec_core exec_core_asserts u_asserts (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.retire      (retire)
	);

	always #5 clk = ~clk;

	task automatic stop_with_message(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "%s", msg);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR %s expected %h actual %h", name, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	// Bound on the whole run, counted in clock cycles
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			stop_with_message("timeout: instructions did not finish");
		end
	end

	// Lines that do not start with a hex field are comments
	task automatic load_vectors();
		int          fd;
		int          code;
		int          n;
		string       line;
		logic [31:0] f_instr;
		logic [31:0] f_kind;
		logic [31:0] f_rd;
		logic [31:0] f_value;
		logic [31:0] f_addr;
		fd = $fopen("testbench/exec_core_testdata.txt", "r");
		if (fd == 0) begin
			stop_with_message("could not open the test data file");
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code != 0) begin
				n = $sscanf(line, "%h %h %h %h %h", f_instr, f_kind, f_rd, f_value, f_addr);
				if (n == 5) begin
					vec_instr.push_back(f_instr);
					vec_kind.push_back(f_kind);
					vec_rd.push_back(f_rd);
					vec_value.push_back(f_value);
					vec_addr.push_back(f_addr);
				end else if (n > 0) begin
					stop_with_message("a test data line has too few fields");
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic check_idle();
		assert (retire.valid === 1'b0)
			else report_mismatch("retire.valid", 32'h0, {31'b0, retire.valid});
	endtask

	task automatic check_retire(input int idx);
		assert (retire.valid === 1'b1)
			else report_mismatch("retire.valid", 32'h1, {31'b0, retire.valid});
		assert (32'(retire.kind) === vec_kind[idx])
			else report_mismatch("retire.kind", vec_kind[idx], 32'(retire.kind));
		assert (32'(retire.rd) === vec_rd[idx])
			else report_mismatch("retire.rd", vec_rd[idx], 32'(retire.rd));
		assert (retire.value === vec_value[idx])
			else report_mismatch("retire.value", vec_value[idx], retire.value);
		assert (retire.addr === vec_addr[idx])
			else report_mismatch("retire.addr", vec_addr[idx], retire.addr);
	endtask

	// Called on a falling edge, returns on the falling edge after the retire
	task automatic run_instruction(input int idx);
		int idle;
		idle = int'($unsigned($random(seed)) % 32'd3);
		// Junk on instr while the strobe is low must not commit
		repeat (idle) begin
			instr_valid = 1'b0;
			instr = $random(seed);
			@(negedge clk);
			check_idle();
		end
		instr_valid = 1'b1;
		instr = vec_instr[idx];
		@(negedge clk);
		check_retire(idx);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = 32'h0;
		load_vectors();
		if (vec_instr.size() == 0) begin
			stop_with_message("the test data file holds no instructions");
		end
		timeout_limit = vec_instr.size() * 4 + 20;

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < vec_instr.size(); i++) begin
			run_instruction(i);
		end

		instr_valid = 1'b0;
		instr = 32'h0;
		@(negedge clk);
		check_idle();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: testbench/exec_core_asserts.sv
`timescale 1ns/1ps

module exec_core_asserts (
	input logic                 clk,
	input logic                 rst,
	input logic                 instr_valid,
	input rv_core_pkg::retire_t retire
);
	import rv_core_pkg::*;

	// Reset leaves no retire pulse behind
	valid_low_after_reset: assert property (
		@(posedge clk) rst |=> !retire.valid
	) else $error("retire.valid high in the cycle after reset");

	// One retire per strobed instruction, one cycle later
	valid_follows_strobe: assert property (
		@(posedge clk) disable iff (rst)
		!$past(rst) |-> (retire.valid == $past(instr_valid))
	) else $error("retire.valid does not match the previous instr_valid");

	// Writes to x0 retire as NONE
	write_has_rd: assert property (
		@(posedge clk) disable iff (rst)
		(retire.valid && (retire.kind == RET_WRITE)) |-> (retire.rd != 5'd0)
	) else $error("WRITE retire with rd zero");

endmodule

// File: rtl/exec_core.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module exec_core (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 instr_valid,
	input  logic [31:0]          instr,
	output rv_core_pkg::retire_t retire
);
	import rv_core_pkg::*;

	localparam int DM_AW = $clog2(`RV_DMEM_WORDS);

	ctrl_t               ctrl;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] alu_b;
	logic [`RV_XLEN-1:0] alu_y;
	logic [`RV_XLEN-1:0] load_data;
	logic [`RV_XLEN-1:0] wb_data;
	logic                rf_we;
	logic                dm_we;
	retire_t             retire_next;

	control u_control (
		.instr (instr),
		.ctrl  (ctrl)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (ctrl.rs1),
		.raddr2 (ctrl.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.we     (rf_we),
		.waddr  (ctrl.rd),
		.wdata  (wb_data)
	);

	// Immediate or second register as operand b
	assign alu_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

	alu u_alu (
		.op (ctrl.alu_op),
		.a  (rs1_data),
		.b  (alu_b),
		.y  (alu_y)
	);

	// Byte address from the ALU, word index taken above the byte offset
	data_mem u_data_mem (
		.clk   (clk),
		.rst   (rst),
		.addr  (alu_y[DM_AW+1:2]),
		.rdata (load_data),
		.we    (dm_we),
		.wdata (rs2_data)
	);

	assign wb_data = ctrl.mem_to_reg ? load_data : alu_y;

	// Nothing is committed without the strobe
	assign rf_we = instr_valid && ctrl.reg_write && (ctrl.rd != '0);
	assign dm_we = instr_valid && ctrl.mem_write;

	// Classify the instruction for the retire record
	always_comb begin
		retire_next = '0;
		retire_next.valid = instr_valid;
		if (instr_valid) begin
			if (ctrl.illegal) begin
				retire_next.kind = RET_ILLEGAL;
			end else if (ctrl.mem_write) begin
				retire_next.kind = RET_STORE;
				retire_next.value = rs2_data;
			end else if (ctrl.reg_write && (ctrl.rd != '0)) begin
				retire_next.kind = RET_WRITE;
				retire_next.rd = ctrl.rd;
				retire_next.value = wb_data;
			end else begin
				retire_next.kind = RET_NONE;
			end
			if (ctrl.mem_read || ctrl.mem_write) begin
				retire_next.addr = alu_y;
			end
		end
	end

	// Single-cycle retire pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			retire <= '0;
		end else begin
			retire <= retire_next;
		end
	end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module data_mem #(
	parameter int AW = $clog2(`RV_DMEM_WORDS)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [AW-1:0]       addr,
	output logic [`RV_XLEN-1:0] rdata,
	input  logic                we,
	input  logic [`RV_XLEN-1:0] wdata
);

	logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];

	// Every word starts out zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Load data is available in the same cycle
	assign rdata = mem[addr];

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module reg_file #(
	parameter int AW = $clog2(`RV_NREGS)
) (
	input  logic                clk,
	input  logic                rst,
	input  logic [AW-1:0]       raddr1,
	input  logic [AW-1:0]       raddr2,
	output logic [`RV_XLEN-1:0] rdata1,
	output logic [`RV_XLEN-1:0] rdata2,
	input  logic                we,
	input  logic [AW-1:0]       waddr,
	input  logic [`RV_XLEN-1:0] wdata
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	// Writes to x0 are dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 always reads zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module alu (
	input  rv_core_pkg::alu_op_t op,
	input  logic [`RV_XLEN-1:0]  a,
	input  logic [`RV_XLEN-1:0]  b,
	output logic [`RV_XLEN-1:0]  y
);
	import rv_core_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// Only the low five bits count for shifts
	assign shamt = b[4:0];

	assign lt_signed = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);

	always_comb begin
		case (op)
			ALU_ADD:    y = a + b;
			ALU_SUB:    y = a - b;
			ALU_AND:    y = a & b;
			ALU_OR:     y = a | b;
			ALU_XOR:    y = a ^ b;
			ALU_SLT:    y = {{(`RV_XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU:   y = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
			ALU_SLL:    y = a << shamt;
			ALU_SRL:    y = a >> shamt;
			// Arithmetic shift keeps the sign bit
			ALU_SRA:    y = $signed(a) >>> shamt;
			// LUI passes its immediate straight through
			ALU_PASS_B: y = b;
			default:    y = '0;
		endcase
	end

endmodule

// File: rtl/control.sv
`timescale 1ns/1ps
`include "rv_core_config.svh"

module control (
	input  logic [31:0]        instr,
	output rv_core_pkg::ctrl_t ctrl
);
	import rv_core_pkg::*;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_u;
	logic                legal;
	alu_op_t             op;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Sign-extended immediates for each format
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_u = {instr[31:12], 12'b0};

	// Opcode, then funct3, then funct7
	always_comb begin
		legal = 1'b0;
		op = ALU_ADD;
		case (opcode)
			OPC_OP: begin
				case (funct3)
					3'b000: begin
						case (funct7)
							7'b0000000: begin legal = 1'b1; op = ALU_ADD; end
							7'b0100000: begin legal = 1'b1; op = ALU_SUB; end
							default: ;
						endcase
					end
					3'b001: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_SLL; end
					3'b010: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_SLT; end
					3'b011: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_SLTU; end
					3'b100: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_XOR; end
					3'b101: begin
						case (funct7)
							7'b0000000: begin legal = 1'b1; op = ALU_SRL; end
							7'b0100000: begin legal = 1'b1; op = ALU_SRA; end
							default: ;
						endcase
					end
					3'b110: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_OR; end
					3'b111: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_AND; end
					default: ;
				endcase
			end
			OPC_OP_IMM: begin
				case (funct3)
					3'b000: begin legal = 1'b1; op = ALU_ADD; end
					3'b010: begin legal = 1'b1; op = ALU_SLT; end
					3'b011: begin legal = 1'b1; op = ALU_SLTU; end
					3'b100: begin legal = 1'b1; op = ALU_XOR; end
					3'b110: begin legal = 1'b1; op = ALU_OR; end
					3'b111: begin legal = 1'b1; op = ALU_AND; end
					// Shift immediates reuse funct7 as the shift type
					3'b001: if (funct7 == 7'b0000000) begin legal = 1'b1; op = ALU_SLL; end
					3'b101: begin
						case (funct7)
							7'b0000000: begin legal = 1'b1; op = ALU_SRL; end
							7'b0100000: begin legal = 1'b1; op = ALU_SRA; end
							default: ;
						endcase
					end
					default: ;
				endcase
			end
			OPC_LUI: begin
				legal = 1'b1;
				op = ALU_PASS_B;
			end
			// Word access only
			OPC_LOAD: if (funct3 == 3'b010) begin legal = 1'b1; op = ALU_ADD; end
			OPC_STORE: if (funct3 == 3'b010) begin legal = 1'b1; op = ALU_ADD; end
			// Branches, jumps, AUIPC and anything else
			default: ;
		endcase
	end

	// Flags follow the opcode class once the encoding is known good
	always_comb begin
		ctrl = '0;
		ctrl.rs1 = instr[19:15];
		ctrl.rs2 = instr[24:20];
		ctrl.rd = instr[11:7];
		ctrl.alu_op = op;
		ctrl.illegal = ~legal;
		if (legal) begin
			ctrl.reg_write = (opcode != OPC_STORE);
			ctrl.mem_read = (opcode == OPC_LOAD);
			ctrl.mem_to_reg = (opcode == OPC_LOAD);
			ctrl.mem_write = (opcode == OPC_STORE);
			ctrl.alu_src_imm = (opcode != OPC_OP);
			case (opcode)
				OPC_STORE: ctrl.imm = imm_s;
				OPC_LUI:   ctrl.imm = imm_u;
				OPC_OP:    ctrl.imm = '0;
				default:   ctrl.imm = imm_i;
			endcase
		end
	end

endmodule

// File: rtl/rv_core_pkg.sv
`include "rv_core_config.svh"

package rv_core_pkg;

	// ALU operation select
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		ALU_SLTU   = 4'd6,
		ALU_SLL    = 4'd7,
		ALU_SRL    = 4'd8,
		ALU_SRA    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	// What a retired instruction did
	typedef enum logic [1:0] {
		RET_NONE    = 2'd0,
		RET_WRITE   = 2'd1,
		RET_STORE   = 2'd2,
		RET_ILLEGAL = 2'd3
	} retire_kind_t;

	// Decoder output
	typedef struct packed {
		logic                reg_write;
		logic                mem_read;
		logic                mem_write;
		logic                mem_to_reg;
		logic                alu_src_imm;
		logic                illegal;
		alu_op_t             alu_op;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] imm;
	} ctrl_t;

	// One record per retired instruction
	typedef struct packed {
		logic                valid;
		retire_kind_t        kind;
		logic [4:0]          rd;
		logic [`RV_XLEN-1:0] value;
		logic [`RV_XLEN-1:0] addr;
	} retire_t;

endpackage

// File: include/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data path width in bits
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

`endif
